// ==== Makefile ====
SOURCES := $(shell cat compile.f)

obj_dir/Vtb_boot_top: compile.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_boot_top \
		-f compile.f -o Vtb_boot_top

.PHONY: run clean

run: obj_dir/Vtb_boot_top
	./obj_dir/Vtb_boot_top

clean:
	rm -rf obj_dir

// ==== compile.f ====
logic/uart_pkg.sv
logic/isa_pkg.sv
logic/uart_rx.sv
logic/uart_collector.sv
logic/instr_mem.sv
logic/boot_top.sv
testbench/tb_boot_top.sv

// ==== logic/boot_top.sv ====
module boot_top #(
  parameter int clks_per_bit = 16,
  parameter int mem_words    = 64
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         rx_serial,
  input  logic [$clog2(mem_words)-1:0] fetch_addr,
  output logic [31:0]                  fetch_data,
  output logic                         start
);
  import isa_pkg::*;

  logic [7:0] rx_byte;
  logic rx_byte_valid;

  instr_u write_instr_data;
  logic [1:0] write_half_en;
  logic [$clog2(mem_words)+1:0] write_byte_address;
  logic write_instr_valid;

  uart_rx #(
    .clks_per_bit(clks_per_bit)
  ) i_uart_rx (
    .clk          (clk),
    .rst          (rst),
    .rx_serial    (rx_serial),
    .rx_byte      (rx_byte),
    .rx_byte_valid(rx_byte_valid)
  );

  uart_collector #(
    .mem_words(mem_words)
  ) i_uart_collector (
    .clk               (clk),
    .rst               (rst),
    .rx_byte           (rx_byte),
    .rx_byte_valid     (rx_byte_valid),
    .write_instr_data  (write_instr_data),
    .write_half_en     (write_half_en),
    .write_byte_address(write_byte_address),
    .write_instr_valid (write_instr_valid),
    .start             (start)
  );

  instr_mem #(
    .mem_words(mem_words)
  ) i_instr_mem (
    .clk               (clk),
    .write_instr_data  (write_instr_data),
    .write_half_en     (write_half_en),
    .write_byte_address(write_byte_address),
    .write_instr_valid (write_instr_valid),
    .fetch_addr        (fetch_addr),
    .fetch_data        (fetch_data)
  );

endmodule

// ==== logic/instr_mem.sv ====
module instr_mem #(
  parameter int mem_words = 64
) (
  input  logic                         clk,
  input  isa_pkg::instr_u              write_instr_data,
  input  logic [1:0]                   write_half_en,
  input  logic [$clog2(mem_words)+1:0] write_byte_address,
  input  logic                         write_instr_valid,
  input  logic [$clog2(mem_words)-1:0] fetch_addr,
  output logic [31:0]                  fetch_data
);

  localparam int idx_w = $clog2(mem_words);

  logic [31:0] mem [mem_words];
  logic [idx_w-1:0] write_idx;

  assign write_idx = write_byte_address[idx_w+1:2];  // byte to word index

  // halfword enables let the short tail patch one half
  always_ff @(posedge clk) begin
    if (write_instr_valid) begin
      if (write_half_en[1]) begin
        mem[write_idx][31:16] <= write_instr_data.half.hi;
      end
      if (write_half_en[0]) begin
        mem[write_idx][15:0] <= write_instr_data.half.lo;
      end
    end
  end

  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];  // one cycle fetch latency
  end

  a_write_in_range: assert property (@(posedge clk)
    write_instr_valid |-> (32'(write_idx) < mem_words))
    else $error("write_byte_address 0x%0h beyond %0d words",
                write_byte_address, mem_words);

endmodule

// ==== logic/isa_pkg.sv ====
package isa_pkg;

  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } instr_halves_t;

  // one fetch word seen as a full instruction or as two compressed halves
  typedef union packed {
    logic [31:0]   word;
    instr_halves_t half;
  } instr_u;

  localparam logic [31:0] nop_word = 32'h0000_0013;  // addi x0, x0, 0
  localparam logic [31:0] halt_word = 32'hffff_ffff;  // end marker and halt
  localparam logic [15:0] halt_half = 16'hffff;

  localparam int tail_nops = 5;  // nops ahead of the halt

endpackage

// ==== logic/uart_collector.sv ====
module uart_collector #(
  parameter int mem_words = 64
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [7:0]                   rx_byte,
  input  logic                         rx_byte_valid,
  output isa_pkg::instr_u              write_instr_data,
  output logic [1:0]                   write_half_en,
  output logic [$clog2(mem_words)+1:0] write_byte_address,
  output logic                         write_instr_valid,
  output logic                         start
);
  import isa_pkg::*;

  localparam int addr_w = $clog2(mem_words) + 2;
  localparam int step_w = $clog2(tail_nops + 2);
  localparam logic [step_w-1:0] last_long = step_w'(tail_nops);
  localparam logic [step_w-1:0] last_short = step_w'(tail_nops + 1);
  localparam instr_u nop_i = instr_u'(nop_word);
  localparam instr_u halt_i = instr_u'(halt_word);

  typedef enum logic [2:0] {
    idle,
    byte_1,
    byte_2,
    byte_3,
    done
  } collect_state_t;

  collect_state_t state;

  instr_u instr_acc;
  logic [addr_w-1:0] byte_count;
  logic take;
  logic last_hi_halt;  // last program word ended on its lower half
  logic tail_active;
  logic short_mode;
  logic [step_w-1:0] tail_step;
  logic [addr_w-1:0] tail_addr;
  logic start_int;

  instr_u wr_data;
  logic [1:0] wr_half_en;
  logic [addr_w-1:0] wr_addr;
  logic wr_valid;

  // no bytes once the tail has started
  assign take = rx_byte_valid && state != done && !tail_active && !start_int;

  always_ff @(posedge clk) begin
    if (take) begin
      case (state)
        idle:    instr_acc.word[7:0] <= rx_byte;
        byte_1:  instr_acc.word[15:8] <= rx_byte;
        byte_2:  instr_acc.word[23:16] <= rx_byte;
        default: instr_acc.word[31:24] <= rx_byte;
      endcase
    end
  end

  always_comb begin
    wr_valid = 1'b0;
    wr_data = instr_acc;
    wr_half_en = 2'b11;
    wr_addr = byte_count - addr_w'(4);
    if (tail_active) begin
      wr_valid = 1'b1;
      wr_addr = tail_addr;
      if (!short_mode) begin
        wr_data = (tail_step == last_long) ? halt_i : nop_i;
      end else if (tail_step == '0) begin
        wr_data.half.hi = nop_i.half.lo;
        wr_data.half.lo = '0;
        wr_half_en = 2'b10;  // keep the last compressed instr
      end else if (tail_step < last_long) begin
        wr_data.half.hi = nop_i.half.lo;  // next nop starts here
        wr_data.half.lo = nop_i.half.hi;
      end else if (tail_step == last_long) begin
        wr_data.half.hi = halt_i.half.lo;
        wr_data.half.lo = nop_i.half.hi;
      end else begin
        wr_data.half.hi = '0;
        wr_data.half.lo = halt_i.half.hi;
      end
    end else if (state == done && instr_acc.word != halt_word) begin
      wr_valid = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      byte_count <= '0;
      last_hi_halt <= 1'b0;
      tail_active <= 1'b0;
      short_mode <= 1'b0;
      tail_step <= '0;
      tail_addr <= '0;
      start_int <= 1'b0;
    end else begin
      if (take) byte_count <= byte_count + 1'b1;
      case (state)
        idle:   if (take) state <= byte_1;
        byte_1: if (take) state <= byte_2;
        byte_2: if (take) state <= byte_3;
        byte_3: if (take) state <= done;
        default: begin
          state <= idle;
          if (instr_acc.word == halt_word) begin
            tail_active <= 1'b1;
            tail_step <= '0;
            short_mode <= last_hi_halt;
            // short tail begins in the upper half of the previous word
            tail_addr <= last_hi_halt ? byte_count - addr_w'(8) : byte_count - addr_w'(4);
          end else begin
            last_hi_halt <= (instr_acc.half.hi == halt_half);
          end
        end
      endcase

      if (tail_active) begin
        tail_step <= tail_step + 1'b1;
        tail_addr <= tail_addr + addr_w'(4);
        if (tail_step == (short_mode ? last_short : last_long)) begin
          tail_active <= 1'b0;
          start_int <= 1'b1;  // held until reset
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      write_instr_valid <= 1'b0;
      start <= 1'b0;
    end else begin
      write_instr_valid <= wr_valid;
      start <= start_int;
    end
  end

  always_ff @(posedge clk) begin
    write_instr_data <= wr_data;
    write_half_en <= wr_half_en;
    write_byte_address <= wr_addr;
  end

  a_no_write_after_start: assert property (@(posedge clk) disable iff (rst)
    start |-> !write_instr_valid)
    else $error("write_instr_valid high while start is high");

  a_word_aligned: assert property (@(posedge clk) disable iff (rst)
    write_instr_valid |-> write_byte_address[1:0] == 2'b00)
    else $error("write_byte_address 0x%0h not word aligned", write_byte_address);

endmodule

// ==== logic/uart_pkg.sv ====
package uart_pkg;

  // 8N1 framing
  localparam int data_bits = 8;  // lsb first on the line
  localparam int stop_bits = 1;

endpackage

// ==== logic/uart_rx.sv ====
module uart_rx #(
  parameter int clks_per_bit = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx_serial,
  output logic [7:0] rx_byte,
  output logic       rx_byte_valid
);
  import uart_pkg::*;

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int idx_w = $clog2(data_bits);
  localparam int stop_w = $clog2(stop_bits + 1);
  localparam logic [cnt_w-1:0] half_bit = cnt_w'(clks_per_bit / 2 - 1);
  localparam logic [cnt_w-1:0] full_bit = cnt_w'(clks_per_bit - 1);
  localparam logic [idx_w-1:0] last_bit = idx_w'(data_bits - 1);
  localparam logic [stop_w-1:0] last_stop = stop_w'(stop_bits - 1);

  typedef enum logic [1:0] {
    idle,
    start_bit,
    data_bit,
    stop_bit
  } rx_state_t;

  rx_state_t state;

  logic [1:0] rx_sync;
  logic rx_s;
  logic [cnt_w-1:0] clk_cnt;
  logic [idx_w-1:0] bit_idx;
  logic [stop_w-1:0] stop_cnt;

  assign rx_s = rx_sync[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_sync <= 2'b11;  // line idles high
    end else begin
      rx_sync <= {rx_sync[0], rx_serial};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      stop_cnt <= '0;
      rx_byte_valid <= 1'b0;
    end else begin
      rx_byte_valid <= 1'b0;
      clk_cnt <= clk_cnt + 1'b1;
      case (state)
        idle: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          stop_cnt <= '0;
          if (!rx_s) state <= start_bit;
        end
        start_bit: begin
          if (clk_cnt == half_bit) begin
            clk_cnt <= '0;
            state <= rx_s ? idle : data_bit;  // line back high means a glitch
          end
        end
        data_bit: begin
          if (clk_cnt == full_bit) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == last_bit) state <= stop_bit;
          end
        end
        default: begin
          if (clk_cnt == full_bit) begin
            clk_cnt <= '0;
            stop_cnt <= stop_cnt + 1'b1;
            if (!rx_s) begin
              state <= idle;  // bad stop bit drops the byte
            end else if (stop_cnt == last_stop) begin
              rx_byte_valid <= 1'b1;
              state <= idle;
            end
          end
        end
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge clk) begin
    if (state == data_bit && clk_cnt == full_bit) begin
      rx_byte <= {rx_s, rx_byte[7:1]};
    end
  end

  a_single_pulse: assert property (@(posedge clk) disable iff (rst)
    rx_byte_valid |=> !rx_byte_valid)
    else $error("rx_byte_valid high on two consecutive cycles");

endmodule

// ==== testbench/tb_boot_top.sv ====
module tb_boot_top;
  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;
  import isa_pkg::*;

  localparam int clks_per_bit = 8;
  localparam int mem_words = 64;
  localparam int fidx_w = $clog2(mem_words);
  localparam int long_words = 12;
  localparam int short_words = 9;
  localparam int extra_bytes = 4;

  // worst case frame is a full frame plus the longest idle gap
  localparam int frame_cycles = (1 + data_bits + stop_bits) * clks_per_bit;
  localparam int byte_cycles = frame_cycles + 3 * clks_per_bit + 1;
  localparam int total_bytes = 4 * (long_words + 1) + extra_bytes + 4 * (short_words + 1);
  localparam int sweep_cycles = 3 * (mem_words + 3);
  localparam int max_cycles = 2 * (total_bytes * byte_cycles + sweep_cycles + 2 * 5 + 3 * 20);

  logic clk = 1'b0;
  logic rst;
  logic rx_serial;
  logic [fidx_w-1:0] fetch_addr;
  logic [31:0] fetch_data;
  logic start;

  logic [31:0] lfsr;
  logic [31:0] image [mem_words];  // expected memory contents
  int img_words;
  logic marker_sent;
  logic sweep_valid;
  logic check_fetch = 1'b0;
  logic [fidx_w-1:0] check_addr;
  logic [31:0] exp_fetch;
  int cycle_count = 0;

  boot_top #(
    .clks_per_bit(clks_per_bit),
    .mem_words   (mem_words)
  ) i_boot_top (
    .clk       (clk),
    .rst       (rst),
    .rx_serial (rx_serial),
    .fetch_addr(fetch_addr),
    .fetch_data(fetch_data),
    .start     (start)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
      stop_with_failure();
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] random_body_word();
    instr_u w;
    w.word = random_bits(32);
    while (w.half.hi == halt_half) begin
      w.word = random_bits(32);  // would look like a marker or a short end
    end
    return w.word;
  endfunction

  function automatic void put_half(input int pos, input logic [15:0] h);
    instr_u w;
    w.word = image[pos / 2];
    if (pos % 2 == 1) begin
      w.half.hi = h;
    end else begin
      w.half.lo = h;
    end
    image[pos / 2] = w.word;
  endfunction

  task automatic drive_bit(input logic v);
    @(posedge clk);
    rx_serial <= v;
    repeat (clks_per_bit - 1) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = int'(random_bits(2));  // 0 gives back-to-back frames
    repeat (gap * clks_per_bit) @(posedge clk);
    drive_bit(1'b0);
    for (int i = 0; i < data_bits; i++) begin
      drive_bit(b[i]);  // lsb first
    end
    repeat (stop_bits) drive_bit(1'b1);
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int i = 0; i < 4; i++) begin
      send_byte(w[8*i +: 8]);
    end
  endtask

  task automatic reset_dut();
    rst <= 1'b1;
    marker_sent <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic load_program(input int n_words, input logic short_end);
    instr_u w;
    int pos;
    logic [31:0] tail_word;
    for (int i = 0; i < n_words; i++) begin
      w.word = random_body_word();
      if (short_end && i == n_words - 1) begin
        w.half.hi = halt_half;
        w.half.lo[0] = 1'b0;  // compressed instr in the lower half
      end
      image[i] = w.word;
      send_word(w.word);
    end
    marker_sent <= 1'b1;
    send_word(halt_word);
    // tail halves start at the marker word, or in the free upper half before it
    pos = short_end ? 2 * n_words - 1 : 2 * n_words;
    for (int k = 0; k <= tail_nops; k++) begin
      tail_word = (k < tail_nops) ? nop_word : halt_word;
      put_half(pos, tail_word[15:0]);
      put_half(pos + 1, tail_word[31:16]);
      pos += 2;
    end
    if (pos % 2 == 1) begin
      put_half(pos, 16'h0000);  // upper half after a shifted halt
    end
    if ((pos + 1) / 2 > img_words) begin
      img_words = (pos + 1) / 2;
    end
  endtask

  task automatic wait_for_start();
    while (!start) @(posedge clk);
  endtask

  task automatic sweep_image();
    for (int a = 0; a < img_words; a++) begin
      @(posedge clk);
      fetch_addr <= fidx_w'(a);
      sweep_valid <= 1'b1;
    end
    @(posedge clk);
    sweep_valid <= 1'b0;
    repeat (2) @(posedge clk);  // last compare
  endtask

  // same one cycle latency as the fetch port
  always @(posedge clk) begin
    check_fetch <= sweep_valid;
    check_addr <= fetch_addr;
    exp_fetch <= image[fetch_addr];
  end

  a_fetch_data: assert property (@(posedge clk) check_fetch |-> fetch_data == exp_fetch)
    else begin
      $display("** Error: fetch_data at word %0d is 0x%08h, expected 0x%08h",
               $sampled(check_addr), $sampled(fetch_data), $sampled(exp_fetch));
      stop_with_failure();
    end

  a_start_at_readback: assert property (@(posedge clk) check_fetch |-> start)
    else begin
      $display("** Error: start is 0x%0h during readback, expected 0x1", $sampled(start));
      stop_with_failure();
    end

  a_start_after_marker: assert property (@(posedge clk) disable iff (rst)
    !marker_sent |-> !start)
    else begin
      $display("** Error: start is 0x%0h before the end marker, expected 0x0",
               $sampled(start));
      stop_with_failure();
    end

  a_start_held: assert property (@(posedge clk) disable iff (rst) start |=> start)
    else begin
      $display("** Error: start is 0x%0h after it rose, expected 0x1", $sampled(start));
      stop_with_failure();
    end

  initial begin
    rst = 1'b1;
    rx_serial = 1'b1;
    fetch_addr = '0;
    sweep_valid = 1'b0;
    marker_sent = 1'b0;
    img_words = 0;
    lfsr = 32'h5369_6a79;
    reset_dut();

    // long tail from the marker word
    load_program(long_words, 1'b0);
    wait_for_start();
    sweep_image();

    // bytes after start
    repeat (extra_bytes) send_byte(8'(random_bits(8)));
    sweep_image();

    reset_dut();
    load_program(short_words, 1'b1);
    wait_for_start();
    sweep_image();

    $display("Test completed successfully");
    $finish;
  end

endmodule
